//--- bench/spiPeriphTb.sv
`timescale 1ns/1ps
`include "spiPeriph_cfg.svh"

module spiPeriphTb;
    import spiRegPkg::*;

    localparam int periodNs  = 8;
    localparam int halfNs    = (`SPI_RST_SCKDIV + 1) * periodNs;  // Slowest SCK half period
    localparam int frameNs   = (2 * `SPI_FRAME_W + 4) * halfNs;   // Bits, select lead, gap
    localparam int numFrames = 36;                                // Frames over all tests
    localparam int accessNs  = 3 * periodNs;
    localparam int numAccess = 300;                               // Config and status accesses
    localparam int limitNs   = 2 * (numFrames * frameNs + numAccess * accessNs);

    logic                 PCLK, PRESETn;
    logic                 PSEL, PENABLE, PWRITE;
    logic [7:0]           PADDR;
    logic [31:0]          PWDATA;
    logic [3:0]           PSTRB;
    logic                 PREADY;
    logic [31:0]          PRDATA;
    logic                 SPICLK, SPIIntr;
    logic [`SPI_CS_W-1:0] SPICS;
    wire                  spiLoop;   // SPIOut wired back to SPIIn
    integer               seed;
    int                   errCount, checkCount, testCount;

    spiPeriph dut (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PSTRB,
        .PREADY, .PRDATA,
        .SPIIn(spiLoop), .SPIOut(spiLoop), .SPICLK, .SPICS, .SPIIntr
    );

    initial begin
        PCLK = 1'b0;
        forever #(periodNs / 2) PCLK = ~PCLK;
    end

    initial begin
        #(limitNs);
        $display("Timeout: the tests did not finish within %0d ns", limitNs);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Check and APB helpers
    ////////////////////////////////////////////////////////////
    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond === 1'b1) else begin
            $display("Error at %0t ns: %s", $time, what);
            errCount++;
        end
    endtask

    task automatic apbAccess(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(negedge PCLK);
        PSEL    = 1'b1;   // Setup phase
        PENABLE = 1'b0;
        PWRITE  = wr;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge PCLK);
        PENABLE = 1'b1;
        while (!PREADY) @(negedge PCLK);   // Interlock stall
        rdata = PRDATA;
        @(negedge PCLK);                    // Completed on the rising edge just passed
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        apbAccess(1'b1, addr, data, ignored);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
        apbAccess(1'b0, addr, 32'h0, data);
    endtask

    // Software flow control, waits for room in the transmit FIFO
    task automatic sendFrame(input logic [7:0] data);
        logic [31:0] rd;
        int polls;
        polls = 0;
        apbRead(regTxData, rd);
        while (rd[31] && polls < 200) begin
            apbRead(regTxData, rd);
            polls++;
        end
        checkTrue(!rd[31], "the transmit FIFO stayed full");
        apbWrite(regTxData, {24'h0, data});
    endtask

    task automatic recvFrame(output logic [7:0] data);
        logic [31:0] rd;
        int polls;
        polls = 0;
        apbRead(regRxData, rd);
        while (rd[31] && polls < 200) begin   // Empty reads do not pop
            apbRead(regRxData, rd);
            polls++;
        end
        checkTrue(!rd[31], "no frame arrived in RXDATA");
        data = rd[7:0];
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic resetTest();
        logic [7:0]  addrs [11];
        logic [31:0] exps [11];
        logic [31:0] rd;
        addrs = '{regSckDiv, regSckMode, regCsId, regCsDef, regCsMode, regFmt,
                  regTxData, regTxMark, regRxMark, regIe, regIp};
        exps  = '{32'd3, 0, 0, 32'hF, 0, 32'h0008_0000, 0, 0, 0, 0, 0};
        checkValue(SPICS, 4'hF, "SPICS after reset");
        checkValue(SPIIntr, 1'b0, "SPIIntr after reset");
        checkValue(SPICLK, 1'b0, "SPICLK after reset");
        for (int i = 0; i < 11; i++) begin
            apbRead(addrs[i], rd);
            checkValue(rd, exps[i], $sformatf("reset value at offset %h", addrs[i]));
        end
        apbRead(regRxData, rd);
        checkValue(rd & 32'hFFFF_FF00, 32'h8000_0000, "RXDATA status after reset");
    endtask

    task automatic fieldTest();
        logic [7:0]  addrs [9];
        logic [31:0] masks [9];
        logic [31:0] defs [9];
        logic [31:0] wr, rd;
        addrs = '{regSckDiv, regSckMode, regCsId, regCsDef, regCsMode, regFmt,
                  regTxMark, regRxMark, regIe};
        masks = '{32'hFFF, 32'h3, 32'h3, 32'hF, 32'h3, 32'h000F_0004, 32'h7, 32'h7, 32'h3};
        defs  = '{32'd3, 0, 0, 32'hF, 0, 32'h0008_0000, 0, 0, 0};
        for (int i = 0; i < 9; i++) begin
            wr = $random(seed);
            apbWrite(addrs[i], wr);
            apbRead(addrs[i], rd);
            checkValue(rd, wr & masks[i], $sformatf("field readback at offset %h", addrs[i]));
        end
        for (int i = 0; i < 9; i++) apbWrite(addrs[i], defs[i]);   // Back to reset state
    endtask

    task automatic modeTest();
        logic [7:0] sent, got;
        for (int mode = 0; mode < 4; mode++) begin
            apbWrite(regSckMode, mode);
            checkValue(SPICLK, mode[1], $sformatf("SPICLK idle level in mode %0d", mode));
            repeat (2) begin
                sent = 8'($random(seed));
                sendFrame(sent);
                recvFrame(got);
                checkValue(got, sent, $sformatf("loopback frame in mode %0d", mode));
            end
        end
        apbWrite(regSckMode, 0);
    endtask

    task automatic lengthTest();
        logic [7:0] sent, got, keep;
        for (int lsb = 0; lsb < 2; lsb++) begin
            for (int len = 1; len <= 8; len++) begin
                apbWrite(regFmt, (len << 16) | (lsb << 2));   // Stalls until the last frame ends
                sent = 8'($random(seed));
                keep = lsb ? (8'hFF >> (8 - len)) : (8'hFF << (8 - len));
                sendFrame(sent);
                recvFrame(got);
                checkValue(got, sent & keep, $sformatf("%0d-bit frame, lsbFirst %0d", len, lsb));
            end
        end
        apbWrite(regFmt, 32'h0008_0000);
    endtask

    task automatic selectTest();
        logic [31:0] rd;
        logic [3:0]  def, act;
        logic [1:0]  id;
        int          polls, seen;
        for (int off = 0; off < 2; off++) begin
            def = 4'($random(seed));
            id  = 2'($random(seed));
            act = off ? def : def ^ (4'b1 << id);   // Off mode never moves a pin
            apbWrite(regCsDef, def);
            apbWrite(regCsId, id);
            apbWrite(regCsMode, off ? 32'd3 : 32'd0);
            checkValue(SPICS, def, "SPICS before the frame");
            sendFrame(8'($random(seed)));
            polls = 0;
            seen  = 0;
            apbRead(regRxData, rd);
            while (rd[31] && polls < 200) begin
                if (rd[30]) begin   // Busy and nothing received yet, frame still running
                    checkValue(SPICS, act, $sformatf("SPICS mid-frame, off %0d", off));
                    seen++;
                end
                apbRead(regRxData, rd);
                polls++;
            end
            checkTrue(seen > 0, "RXDATA never showed busy while the frame ran");
            apbRead(regCsMode, rd);   // Interlock releases as busy falls
            checkValue(SPICS, def, "SPICS after busy falls");
        end
        apbWrite(regCsMode, 0);
        apbWrite(regCsDef, 32'hF);
    endtask

    task automatic overflowTest();
        logic [7:0]  sent [10];
        logic [31:0] rd;
        int          polls;
        apbWrite(regSckDiv, 1);
        apbWrite(regTxMark, 1);   // IP bit 0 means transmit FIFO empty
        apbWrite(regRxMark, 3);
        apbWrite(regIe, 2);
        for (int i = 0; i < 10; i++) begin
            sent[i] = 8'($random(seed));
            sendFrame(sent[i]);
        end
        polls = 0;
        apbRead(regIp, rd);
        while (!rd[0] && polls < 400) begin
            apbRead(regIp, rd);
            polls++;
        end
        checkTrue(rd[0], "IP bit 0 never rose as the transmit FIFO drained");
        apbRead(regFmt, rd);   // Held off until the tenth frame ends
        apbRead(regIp, rd);
        checkValue(rd[1:0], 2'b11, "IP with a full receive FIFO");
        checkValue(SPIIntr, 1'b1, "SPIIntr with a full receive FIFO");
        for (int i = 0; i < 8; i++) begin
            apbRead(regRxData, rd);
            checkValue(rd & 32'hC000_00FF, {24'h0, sent[i]}, $sformatf("received frame %0d", i));
        end
        apbRead(regRxData, rd);
        checkValue(rd[31], 1'b1, "RXDATA empty flag after eight frames");
        apbRead(regIp, rd);
        checkValue(rd[1], 1'b0, "IP bit 1 with an empty receive FIFO");
        checkValue(SPIIntr, 1'b0, "SPIIntr with an empty receive FIFO");
    endtask

    task automatic testReport(input string name, input int errStart);
        testCount++;
        $display("test %s finished with %0d errors", name, errCount - errStart);
    endtask

    initial begin
        int errStart;
        seed       = 32'ha3b8;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        PRESETn    = 1'b0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = '0;
        PWDATA     = '0;
        PSTRB      = 4'hF;
        repeat (2) @(negedge PCLK);
        PRESETn = 1'b1;

        errStart = errCount;
        resetTest();
        testReport("reset values", errStart);
        errStart = errCount;
        fieldTest();
        testReport("register fields", errStart);
        errStart = errCount;
        modeTest();
        testReport("clock modes", errStart);
        errStart = errCount;
        lengthTest();
        testReport("frame lengths", errStart);
        errStart = errCount;
        selectTest();
        testReport("chip select", errStart);
        errStart = errCount;
        overflowTest();
        testReport("FIFO overflow", errStart);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/spiPeriph_props.sv
`timescale 1ns/1ps
`include "spiPeriph_cfg.svh"

module spiEngineProps (
    input logic                    PCLK,
    input logic                    PRESETn,
    input spiXferPkg::xferStateE   state,
    input logic                    sckPol,
    input logic                    SPICLK,
    input logic [`SPI_CS_W-1:0]    csDef,
    input logic [`SPI_CS_W-1:0]    SPICS,
    input logic                    txPop,
    input logic                    rxPush
);
    import spiXferPkg::*;

    // Serial clock parks at its polarity between frames
    idleClock: assert property (@(posedge PCLK) disable iff (!PRESETn)
        (state == csIdle) |-> (SPICLK == sckPol))
        else $error("SPICLK left its idle level in csIdle");

    oneSelect: assert property (@(posedge PCLK) disable iff (!PRESETn)
        $countones(SPICS ^ csDef) <= 1)   // Only the CSID pin may move
        else $error("more than one SPICS pin moved away from CSDEF");

    // FIFO strobes last one PCLK
    popPulse: assert property (@(posedge PCLK) disable iff (!PRESETn) txPop |=> !txPop)
        else $error("txPop stayed high for two cycles");

    pushPulse: assert property (@(posedge PCLK) disable iff (!PRESETn) rxPush |=> !rxPush)
        else $error("rxPush stayed high for two cycles");

endmodule

bind spiXferEngine spiEngineProps props (
    .PCLK, .PRESETn, .state, .sckPol, .SPICLK, .csDef, .SPICS, .txPop, .rxPush
);

//--- hw/spiFifo.sv
`timescale 1ns/1ps
`include "spiPeriph_cfg.svh"

module spiFifo #(
    parameter int DW    = `SPI_FRAME_W,
    parameter int DEPTH = `SPI_FIFO_DEPTH
) (
    input  logic                         PCLK,
    input  logic                         PRESETn,
    input  logic                         push,
    input  logic                         pop,
    input  logic [DW-1:0]                wrData,
    output logic [DW-1:0]                rdData,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH+1);

    logic [DW-1:0] mem [DEPTH];
    logic [AW-1:0] wrPtr, rdPtr;
    logic          doPush, doPop;

    assign full   = (count == CW'(DEPTH));
    assign empty  = (count == '0);
    assign doPush = push & ~full;   // Overflow guard
    assign doPop  = pop & ~empty;   // Underflow guard
    assign rdData = mem[rdPtr];     // Head is visible without a pop

    always_ff @(posedge PCLK) begin
        if (doPush) mem[wrPtr] <= wrData;
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= (wrPtr == AW'(DEPTH-1)) ? '0 : wrPtr + 1'b1;
            if (doPop)  rdPtr <= (rdPtr == AW'(DEPTH-1)) ? '0 : rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

//--- hw/spiPeriph.sv
`timescale 1ns/1ps
`include "spiPeriph_cfg.svh"

module spiPeriph (
    input  logic                    PCLK,
    input  logic                    PRESETn,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [7:0]              PADDR,
    input  logic [31:0]             PWDATA,
    input  logic [3:0]              PSTRB,
    output logic                    PREADY,
    output logic [31:0]             PRDATA,
    input  logic                    SPIIn,
    output logic                    SPIOut,
    output logic                    SPICLK,
    output logic [`SPI_CS_W-1:0]    SPICS,
    output logic                    SPIIntr
);
    import spiRegPkg::*;

    // Live configuration
    logic [`SPI_DIV_W-1:0]         sckDiv;
    logic                          sckPol, sckPha, lsbFirst;
    logic [$clog2(`SPI_CS_W)-1:0]  csId;
    logic [`SPI_CS_W-1:0]          csDef;
    csModeE                        csMode;
    logic [3:0]                    frameLen;

    // FIFO traffic
    logic                          txPush, txPop, txFull, txEmpty;
    logic                          rxPush, rxPop, rxEmpty;
    logic [`SPI_FRAME_W-1:0]       txWrData, txData, rxFrame, rxData;
    logic [`SPI_CNT_W-1:0]         txCount, rxCount;
    logic                          busy;

    spiRegFile regFile (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PSTRB,
        .PREADY, .PRDATA,
        .sckDiv, .sckPol, .sckPha, .csId, .csDef, .csMode, .frameLen, .lsbFirst,
        .txPush, .txWrData, .rxPop,
        .txFull, .txCount, .rxData, .rxEmpty, .rxCount,
        .busy, .SPIIntr
    );

    spiFifo #(.DW(`SPI_FRAME_W), .DEPTH(`SPI_FIFO_DEPTH)) txFifo (
        .PCLK, .PRESETn, .push(txPush), .pop(txPop), .wrData(txWrData),
        .rdData(txData), .full(txFull), .empty(txEmpty), .count(txCount)
    );

    // Receive overflow is handled inside the FIFO
    spiFifo #(.DW(`SPI_FRAME_W), .DEPTH(`SPI_FIFO_DEPTH)) rxFifo (
        .PCLK, .PRESETn, .push(rxPush), .pop(rxPop), .wrData(rxFrame),
        .rdData(rxData), .full(), .empty(rxEmpty), .count(rxCount)
    );

    spiXferEngine engine (
        .PCLK, .PRESETn,
        .sckDiv, .sckPol, .sckPha, .csId, .csDef, .csMode, .frameLen, .lsbFirst,
        .txData, .txEmpty, .txPop, .rxFrame, .rxPush, .busy,
        .SPIIn, .SPIOut, .SPICLK, .SPICS
    );

endmodule

//--- hw/spiPeriph_cfg.svh
`ifndef SPI_PERIPH_CFG_SVH
`define SPI_PERIPH_CFG_SVH

// FIFO geometry
`define SPI_FIFO_DEPTH 8     // Entries per FIFO
`define SPI_FIFO_AW    3     // Pointer and watermark width
`define SPI_CNT_W      4     // Occupancy count holds 0 to DEPTH

// Datapath widths
`define SPI_FRAME_W    8     // One serial frame
`define SPI_DIV_W      12    // SCKDIV field
`define SPI_CS_W       4     // Chip-select pins

// Register reset values
`define SPI_RST_SCKDIV 12'd3
`define SPI_RST_CSDEF  4'hF  // All selects inactive high
`define SPI_RST_LEN    4'd8  // Full byte frames

`endif

//--- hw/spiRegFile.sv
`timescale 1ns/1ps
`include "spiPeriph_cfg.svh"

module spiRegFile (
    input  logic                         PCLK,
    input  logic                         PRESETn,
    input  logic                         PSEL,
    input  logic                         PENABLE,
    input  logic                         PWRITE,
    input  logic [7:0]                   PADDR,
    input  logic [31:0]                  PWDATA,
    input  logic [3:0]                   PSTRB,     // Word-only registers
    output logic                         PREADY,
    output logic [31:0]                  PRDATA,
    output logic [`SPI_DIV_W-1:0]        sckDiv,
    output logic                         sckPol,
    output logic                         sckPha,
    output logic [$clog2(`SPI_CS_W)-1:0] csId,
    output logic [`SPI_CS_W-1:0]         csDef,
    output spiRegPkg::csModeE            csMode,
    output logic [3:0]                   frameLen,
    output logic                         lsbFirst,
    output logic                         txPush,
    output logic [`SPI_FRAME_W-1:0]      txWrData,
    output logic                         rxPop,
    input  logic                         txFull,
    input  logic [`SPI_CNT_W-1:0]        txCount,
    input  logic [`SPI_FRAME_W-1:0]      rxData,
    input  logic                         rxEmpty,
    input  logic [`SPI_CNT_W-1:0]        rxCount,
    input  logic                         busy,
    output logic                         SPIIntr
);
    import spiRegPkg::*;

    regAddrE                addr;
    logic                   wrEn, rdDone;
    logic [`SPI_FIFO_AW-1:0] txMark, rxMark;
    logic [1:0]             ie, ip;
    logic [31:0]            rdMux;

    ////////////////////////////////////////////////////////////
    // APB decode and interlock
    ////////////////////////////////////////////////////////////
    assign addr = regAddrE'({PADDR[7:2], 2'b00});
    // Data and status paths never stall, configuration waits for idle
    assign PREADY = (addr inside {regTxData, regRxData, regIp}) | ~busy;
    assign wrEn   = PSEL & PENABLE & PWRITE & PREADY;
    assign rdDone = PSEL & PENABLE & ~PWRITE & PREADY;
    // Pop only the frame the read returned, not one that arrived after PRDATA
    assign rxPop  = rdDone & (addr == regRxData) & ~PRDATA[31];

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            sckDiv   <= `SPI_RST_SCKDIV;
            sckPol   <= 1'b0;
            sckPha   <= 1'b0;
            csId     <= '0;
            csDef    <= `SPI_RST_CSDEF;
            csMode   <= csAuto;
            frameLen <= `SPI_RST_LEN;
            lsbFirst <= 1'b0;
            txMark   <= '0;
            rxMark   <= '0;
            ie       <= '0;
        end else if (wrEn) begin
            case (addr)
                regSckDiv:  sckDiv <= PWDATA[`SPI_DIV_W-1:0];
                regSckMode: {sckPol, sckPha} <= PWDATA[1:0];
                regCsId:    csId <= PWDATA[$clog2(`SPI_CS_W)-1:0];
                regCsDef:   csDef <= PWDATA[`SPI_CS_W-1:0];
                regCsMode:  csMode <= csModeE'(PWDATA[1:0]);
                regFmt: begin
                    frameLen <= PWDATA[19:16];
                    lsbFirst <= PWDATA[2];
                end
                regTxMark:  txMark <= PWDATA[`SPI_FIFO_AW-1:0];
                regRxMark:  rxMark <= PWDATA[`SPI_FIFO_AW-1:0];
                regIe:      ie <= PWDATA[1:0];
                default:    ;   // Data and read-only registers
            endcase
        end
    end

    // Transmit push lands one cycle after the write, dropped when full
    always_ff @(posedge PCLK) begin
        if (!PRESETn) txPush <= 1'b0;
        else          txPush <= wrEn & (addr == regTxData) & ~txFull;
    end

    always_ff @(posedge PCLK) begin
        if (wrEn && addr == regTxData) txWrData <= PWDATA[`SPI_FRAME_W-1:0];
    end

    ////////////////////////////////////////////////////////////
    // Watermark interrupts
    ////////////////////////////////////////////////////////////
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            ip <= '0;
        end else begin
            ip[0] <= (txCount < {1'b0, txMark});   // Transmit running low
            ip[1] <= (rxCount > {1'b0, rxMark});   // Receive filling up
        end
    end

    assign SPIIntr = |(ip & ie);

    // Readback mux, registered so data is ready in the access phase
    always_comb begin
        rdMux = '0;
        case (addr)
            regSckDiv:  rdMux[`SPI_DIV_W-1:0] = sckDiv;
            regSckMode: rdMux[1:0] = {sckPol, sckPha};
            regCsId:    rdMux[$clog2(`SPI_CS_W)-1:0] = csId;
            regCsDef:   rdMux[`SPI_CS_W-1:0] = csDef;
            regCsMode:  rdMux[1:0] = csMode;
            regFmt: begin
                rdMux[19:16] = frameLen;
                rdMux[2]     = lsbFirst;
            end
            regTxData:  rdMux[31] = txFull;
            regRxData:  rdMux = {rxEmpty, busy, 22'b0, rxData};
            regTxMark:  rdMux[`SPI_FIFO_AW-1:0] = txMark;
            regRxMark:  rdMux[`SPI_FIFO_AW-1:0] = rxMark;
            regIe:      rdMux[1:0] = ie;
            regIp:      rdMux[1:0] = ip;
            default:    rdMux = '0;   // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge PCLK) begin
        PRDATA <= rdMux;
    end

endmodule

//--- hw/spiRegPkg.sv
package spiRegPkg;

    ////////////////////////////////////////////////////////////
    // APB register map, word offsets
    ////////////////////////////////////////////////////////////
    typedef enum logic [7:0] {
        regSckDiv  = 8'h00,
        regSckMode = 8'h04,  // Bit 1 polarity, bit 0 phase
        regCsId    = 8'h10,
        regCsDef   = 8'h14,
        regCsMode  = 8'h18,
        regFmt     = 8'h40,  // Length in 19:16, endian in bit 2
        regTxData  = 8'h48,
        regRxData  = 8'h4C,
        regTxMark  = 8'h50,
        regRxMark  = 8'h54,
        regIe      = 8'h70,
        regIp      = 8'h74
    } regAddrE;

    // Chip-select behaviour between frames
    typedef enum logic [1:0] {
        csAuto = 2'd0,  // Assert per frame
        csHold = 2'd2,  // Keep asserted until mode changes
        csOff  = 2'd3   // Pins follow CSDEF only
    } csModeE;

endpackage

//--- hw/spiXferEngine.sv
`timescale 1ns/1ps
`include "spiPeriph_cfg.svh"

module spiXferEngine (
    input  logic                         PCLK,
    input  logic                         PRESETn,
    input  logic [`SPI_DIV_W-1:0]        sckDiv,
    input  logic                         sckPol,
    input  logic                         sckPha,
    input  logic [$clog2(`SPI_CS_W)-1:0] csId,
    input  logic [`SPI_CS_W-1:0]         csDef,
    input  spiRegPkg::csModeE            csMode,
    input  logic [3:0]                   frameLen,
    input  logic                         lsbFirst,
    input  logic [`SPI_FRAME_W-1:0]      txData,
    input  logic                         txEmpty,
    output logic                         txPop,
    output logic [`SPI_FRAME_W-1:0]      rxFrame,
    output logic                         rxPush,
    output logic                         busy,
    input  logic                         SPIIn,
    output logic                         SPIOut,
    output logic                         SPICLK,
    output logic [`SPI_CS_W-1:0]         SPICS
);
    import spiRegPkg::*;
    import spiXferPkg::*;

    xferStateE               state;
    logic [`SPI_DIV_W-1:0]   divCnt;
    logic                    tick;        // One pulse per SCK half period
    logic [3:0]              bitCnt;      // Trailing edges seen this frame
    logic                    frameDone, loadNow;
    logic                    leadEdge, trailEdge, sampleEn, shiftEn, lastSample;
    logic [`SPI_FRAME_W-1:0] txShift, rxShift, rxAligned;
    logic [3:0]              alignAmt;
    logic                    csActive;

    ////////////////////////////////////////////////////////////
    // Half-period divider, SCK = PCLK / (2 * (SCKDIV + 1))
    ////////////////////////////////////////////////////////////
    assign tick = (divCnt >= sckDiv);   // >= covers a lowered SCKDIV

    always_ff @(posedge PCLK) begin
        if (!PRESETn || tick) divCnt <= '0;
        else                  divCnt <= divCnt + 1'b1;
    end

    // Frame sequencing
    assign frameDone = (state == active0) && (bitCnt == frameLen);
    assign loadNow   = tick & ~txEmpty &
                       ((state == csIdle) | ((state == holdWait) & (csMode == csHold)));
    assign txPop     = loadNow;   // Head consumed as it enters the shifter

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state  <= csIdle;
            bitCnt <= '0;
        end else if (tick) begin
            if (loadNow) bitCnt <= '0;
            case (state)
                csIdle:   if (loadNow) state <= active0;   // Select leads SCK by half period
                active0: begin
                    if (frameDone) state <= (csMode == csHold) ? holdWait : interCs;
                    else           state <= active1;        // Leading edge
                end
                active1: begin
                    state  <= active0;                      // Trailing edge
                    bitCnt <= bitCnt + 4'd1;
                end
                interCs:  state <= csIdle;
                holdWait: begin
                    if (csMode != csHold) state <= interCs;  // Mode change releases select
                    else if (loadNow)     state <= active0;
                end
                default:  state <= csIdle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Serial clock and data edges
    ////////////////////////////////////////////////////////////
    assign SPICLK    = sckPol ^ (state == active1);
    assign busy      = (state == active0) | (state == active1);
    assign leadEdge  = tick & (state == active0) & ~frameDone;
    assign trailEdge = tick & (state == active1);
    // Phase 1 keeps the first bit on the pin until the first leading edge
    assign shiftEn    = sckPha ? (leadEdge & (bitCnt != '0)) : trailEdge;
    assign sampleEn   = sckPha ? trailEdge : leadEdge;
    assign lastSample = sampleEn & (bitCnt == frameLen - 4'd1);

    // Transmit shifter always sends its MSB
    always_ff @(posedge PCLK) begin
        if (!PRESETn)     txShift <= '0;
        else if (loadNow) txShift <= lsbFirst ? flipFrame(txData) : txData;
        else if (shiftEn) txShift <= {txShift[`SPI_FRAME_W-2:0], 1'b0};
    end

    assign SPIOut = txShift[`SPI_FRAME_W-1];

    always_ff @(posedge PCLK) begin
        if (loadNow)       rxShift <= '0;
        else if (sampleEn) rxShift <= {rxShift[`SPI_FRAME_W-2:0], SPIIn};
    end

    // Push follows the final sample so the shifter holds the whole frame
    always_ff @(posedge PCLK) begin
        if (!PRESETn) rxPush <= 1'b0;
        else          rxPush <= lastSample;
    end

    // Short frames sit in the low bits, move them up to the MSB
    assign alignAmt  = 4'(`SPI_FRAME_W) - frameLen;
    assign rxAligned = rxShift << alignAmt;
    assign rxFrame   = lsbFirst ? flipFrame(rxAligned) : rxAligned;

    ////////////////////////////////////////////////////////////
    // Chip select
    ////////////////////////////////////////////////////////////
    assign csActive = busy | (state == holdWait);

    always_comb begin
        SPICS = csDef;
        if (csActive && csMode != csOff) begin
            SPICS[csId] = ~csDef[csId];   // Only the selected pin moves
        end
    end

endmodule

//--- hw/spiXferPkg.sv
`include "spiPeriph_cfg.svh"

package spiXferPkg;

    // Frame sequencer states
    typedef enum logic [2:0] {
        csIdle,    // Waiting for transmit data
        active0,   // SCK at idle level
        active1,   // SCK at active level
        interCs,   // Half-period gap after release
        holdWait   // Select held between frames
    } xferStateE;

    // Bit reversal for LSB-first frames
    function automatic logic [`SPI_FRAME_W-1:0] flipFrame(
        input logic [`SPI_FRAME_W-1:0] d
    );
        logic [`SPI_FRAME_W-1:0] r;
        for (int i = 0; i < `SPI_FRAME_W; i++) begin
            r[i] = d[`SPI_FRAME_W-1-i];
        end
        return r;
    endfunction

endpackage

//--- spiPeriph.f
+incdir+hw
hw/spiRegPkg.sv
hw/spiXferPkg.sv
hw/spiFifo.sv
hw/spiRegFile.sv
hw/spiXferEngine.sv
hw/spiPeriph.sv
bench/spiPeriph_props.sv
bench/spiPeriphTb.sv
